// ==== design/armPkg.sv ====
package armPkg;

  // ==========================================================================
  // Instruction word views
  // ==========================================================================

  // Data-processing layout, bits 31 down to 0
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  opClass;
    logic        immBit;
    logic [3:0]  opcode;
    logic        sBit;
    logic [3:0]  rn;
    logic [3:0]  rd;
    // Rotate and imm8, or shift amount, shift kind and rm
    logic [11:0] operand;
  } dataProcFields;

  // Single data transfer layout with immediate offset
  typedef struct packed {
    logic [3:0]  cond;
    logic [1:0]  opClass;
    logic        regOffset;
    logic        preIndex;
    logic        up;
    logic        byteBit;
    logic        writeBack;
    logic        load;
    logic [3:0]  rn;
    logic [3:0]  rd;
    logic [11:0] offset12;
  } memFields;

  // Same 32 bits read two ways
  typedef union packed {
    dataProcFields dataProcView;
    memFields      memView;
  } instrWord;

  // ==========================================================================
  // Encodings
  // ==========================================================================

  // ARM data-processing opcodes
  typedef enum logic [3:0] {
    opAnd = 4'b0000,
    opEor = 4'b0001,
    opSub = 4'b0010,
    opRsb = 4'b0011,
    opAdd = 4'b0100,
    opOrr = 4'b1100,
    opMov = 4'b1101,
    opBic = 4'b1110,
    opMvn = 4'b1111
  } aluOp;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftType;

  // Operand bypass source in execute
  typedef enum logic [1:0] {
    none  = 2'b00,
    fromM = 2'b01,
    fromW = 2'b10
  } fwdSel;

  // ==========================================================================
  // Bundles
  // ==========================================================================

  // Per-instruction control, 14 bits
  typedef struct packed {
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic byteAccess;
    logic aluSrcImm;
    aluOp op;
    logic invertB;
    logic reverseInputs;
    logic carryIn;
    logic useShift;
    logic passB;
  } ctrlSig;

  typedef struct packed {
    logic [3:0] ra1;
    logic [3:0] ra2;
    logic [3:0] wa;
  } regAddrs;

  // Memory-stage data port, 70 bits
  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  byteEn;
    logic        read;
    logic        write;
  } memReq;

endpackage

// ==== design/immRotator.sv ====
module immRotator (
  input  armPkg::instrWord instr,
  input  logic             isMem,
  output logic [31:0]      imm
);

  logic [31:0] imm8Wide;
  logic [4:0]  rotAmount;
  logic [63:0] doubled;

  // Rotate field counts in steps of two
  assign rotAmount = {instr.dataProcView.operand[11:8], 1'b0};
  assign imm8Wide  = {24'b0, instr.dataProcView.operand[7:0]};

  // Right rotate via a doubled word, low half is the result
  assign doubled = {imm8Wide, imm8Wide} >> rotAmount;

  // Transfer offsets are plain zero-extended
  assign imm = isMem ? {20'b0, instr.memView.offset12} : doubled[31:0];

endmodule

// ==== design/barrelShifter.sv ====
module barrelShifter (
  input  logic [31:0]     value,
  input  armPkg::shiftType kind,
  input  logic [4:0]      amount,
  output logic [31:0]     result
);

  logic [63:0] rotated;

  // Rotate right through a doubled copy
  assign rotated = {value, value} >> amount;

  always_comb begin
    case (kind)
      armPkg::shLsl: begin
        result = value << amount;
      end
      armPkg::shLsr: begin
        // Encoded zero stands for a shift of 32
        result = (amount == 5'd0) ? 32'd0 : value >> amount;
      end
      armPkg::shAsr: begin
        // Same rule, so the sign fills the word
        if (amount == 5'd0) begin
          result = {32{value[31]}};
        end else begin
          result = $signed(value) >>> amount;
        end
      end
      default: begin
        // ROR, no RRX form
        result = rotated[31:0];
      end
    endcase
  end

endmodule

// ==== design/armAlu.sv ====
module armAlu (
  input  logic [31:0] a,
  input  logic [31:0] b,
  input  armPkg::aluOp op,
  input  logic        invertB,
  input  logic        reverseInputs,
  input  logic        carryIn,
  input  logic        passB,
  output logic [31:0] y
);

  logic [31:0] srcA;
  logic [31:0] srcB;
  logic [31:0] bEff;
  logic [31:0] sum;

  // RSB swaps the operands before anything else
  assign srcA = reverseInputs ? b : a;
  assign srcB = reverseInputs ? a : b;

  // Inverted B serves SUB, RSB, BIC and MVN
  assign bEff = invertB ? ~srcB : srcB;

  // Subtract is add of inverse plus one
  assign sum = srcA + bEff + {31'b0, carryIn};

  always_comb begin
    if (passB) begin
      // MOV and MVN
      y = bEff;
    end else begin
      case (op)
        armPkg::opAnd, armPkg::opBic: y = srcA & bEff;
        armPkg::opEor:                y = srcA ^ bEff;
        armPkg::opOrr:                y = srcA | bEff;
        default:                      y = sum;
      endcase
    end
  end

endmodule

// ==== design/regFile.sv ====
module regFile (
  input  logic        clk,
  input  logic        arstN,
  input  logic        we,
  input  logic [3:0]  ra1,
  input  logic [3:0]  ra2,
  input  logic [3:0]  wa,
  input  logic [31:0] wd,
  input  logic [31:0] pcPlus8,
  output logic [31:0] rd1,
  output logic [31:0] rd2
);

  // r0 to r14, r15 is not stored
  logic [31:0] regs [15];

  // Read with bypass of the write in flight
  function automatic logic [31:0] readPort(input logic [3:0] ra);
    if (ra == 4'd15) begin
      return pcPlus8;
    end else if (we && wa == ra) begin
      return wd;
    end
    return regs[ra];
  endfunction

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < 15; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != 4'd15) begin
      regs[wa] <= wd;
    end
  end

  always_comb begin
    rd1 = readPort(ra1);
    rd2 = readPort(ra2);
  end

endmodule

// ==== design/byteLaneUnit.sv ====
module byteLaneUnit (
  input  logic [31:0] storeData,
  input  logic        byteAccess,
  input  logic [1:0]  addrLow,
  output logic [31:0] wdata,
  output logic [3:0]  byteEn,
  input  logic [31:0] loadWordW,
  input  logic        byteAccessW,
  input  logic [1:0]  addrLowW,
  output logic [31:0] loadData
);

  logic [7:0] selByte;

  // Store side in memory stage
  always_comb begin
    if (byteAccess) begin
      // Low byte on every lane, enable picks one
      wdata  = {4{storeData[7:0]}};
      byteEn = 4'b0001 << addrLow;
    end else begin
      wdata  = storeData;
      byteEn = 4'hF;
    end
  end

  // Load side in writeback, little-endian lanes
  assign selByte  = loadWordW[8*addrLowW +: 8];
  assign loadData = byteAccessW ? {24'b0, selByte} : loadWordW;

endmodule

// ==== design/armDecoder.sv ====
module armDecoder (
  input  logic             clk,
  input  logic             arstN,
  input  armPkg::instrWord instrD,
  input  logic             stallD,
  input  logic             bubbleE,
  output armPkg::regAddrs  addrsD,
  output armPkg::regAddrs  addrsE,
  output logic [3:0]       waM,
  output logic [3:0]       waW,
  output armPkg::ctrlSig   ctrlE,
  output armPkg::ctrlSig   ctrlM,
  output armPkg::ctrlSig   ctrlW
);

  armPkg::ctrlSig ctrlD;

  always_comb begin
    ctrlD  = '0;
    addrsD = '0;
    case (instrD.dataProcView.opClass)
      2'b00: begin
        // Data processing with B from rm or the immediate
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = instrD.dataProcView.immBit;
        ctrlD.useShift  = !instrD.dataProcView.immBit;
        ctrlD.op        = armPkg::aluOp'(instrD.dataProcView.opcode);
        addrsD.ra1      = instrD.dataProcView.rn;
        addrsD.ra2      = instrD.dataProcView.operand[3:0];
        addrsD.wa       = instrD.dataProcView.rd;
        case (ctrlD.op)
          armPkg::opSub: begin
            ctrlD.invertB = 1'b1;
            ctrlD.carryIn = 1'b1;
          end
          armPkg::opRsb: begin
            ctrlD.invertB       = 1'b1;
            ctrlD.reverseInputs = 1'b1;
            ctrlD.carryIn       = 1'b1;
          end
          armPkg::opBic: ctrlD.invertB = 1'b1;
          armPkg::opMov: ctrlD.passB = 1'b1;
          armPkg::opMvn: begin
            ctrlD.invertB = 1'b1;
            ctrlD.passB   = 1'b1;
          end
          armPkg::opAnd, armPkg::opEor, armPkg::opAdd, armPkg::opOrr: begin
          end
          // Flag-only and carry ops are not supported
          default: ctrlD.regWrite = 1'b0;
        endcase
      end
      2'b01: begin
        // Base plus or minus offset with rd as the data register
        ctrlD.regWrite   = instrD.memView.load;
        ctrlD.memRead    = instrD.memView.load;
        ctrlD.memWrite   = !instrD.memView.load;
        ctrlD.byteAccess = instrD.memView.byteBit;
        ctrlD.aluSrcImm  = 1'b1;
        ctrlD.op         = armPkg::opAdd;
        ctrlD.invertB    = !instrD.memView.up;
        ctrlD.carryIn    = !instrD.memView.up;
        addrsD.ra1       = instrD.memView.rn;
        addrsD.ra2       = instrD.memView.rd;
        addrsD.wa        = instrD.memView.rd;
      end
      default: begin
      end
    endcase
  end

  // Control pipeline where a bubble enters execute as all zeros
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctrlE  <= '0;
      addrsE <= '0;
      ctrlM  <= '0;
      waM    <= '0;
      ctrlW  <= '0;
      waW    <= '0;
    end else begin
      if (bubbleE) begin
        ctrlE  <= '0;
        addrsE <= '0;
      end else begin
        ctrlE  <= ctrlD;
        addrsE <= addrsD;
      end
      ctrlM <= ctrlE;
      waM   <= addrsE.wa;
      ctrlW <= ctrlM;
      waW   <= waM;
    end
  end

  // No write ever reaches the PC slot
  assert property (@(posedge clk) disable iff (!arstN)
    ctrlW.regWrite |-> waW != 4'd15);

endmodule

// ==== design/hazardUnit.sv ====
module hazardUnit (
  input  logic            clk,
  input  logic            arstN,
  input  armPkg::regAddrs addrsD,
  input  armPkg::regAddrs addrsE,
  input  logic [3:0]      waM,
  input  logic [3:0]      waW,
  input  armPkg::ctrlSig  ctrlE,
  input  armPkg::ctrlSig  ctrlM,
  input  armPkg::ctrlSig  ctrlW,
  output armPkg::fwdSel   forwardA,
  output armPkg::fwdSel   forwardB,
  output logic            stallF,
  output logic            stallD,
  output logic            bubbleE
);

  logic loadUse;

  // Newest producer wins
  // Load data is not ready in memory stage
  function automatic armPkg::fwdSel pickFwd(input logic [3:0] src);
    if (ctrlM.regWrite && !ctrlM.memRead && waM == src) begin
      return armPkg::fromM;
    end else if (ctrlW.regWrite && waW == src) begin
      return armPkg::fromW;
    end
    return armPkg::none;
  endfunction

  always_comb begin
    forwardA = pickFwd(addrsE.ra1);
    forwardB = pickFwd(addrsE.ra2);
  end

  // Load in execute feeding the word in decode
  assign loadUse = ctrlE.memRead &&
                   (addrsE.wa == addrsD.ra1 || addrsE.wa == addrsD.ra2);

  assign stallF  = loadUse;
  assign stallD  = loadUse;
  assign bubbleE = loadUse;

  // The bubble clears the load from execute, so one cycle only
  assert property (@(posedge clk) disable iff (!arstN)
    loadUse |=> !loadUse);

endmodule

// ==== design/armDatapath.sv ====
module armDatapath #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic             clk,
  input  logic             arstN,
  output logic [31:0]      pcF,
  input  logic [31:0]      instrF,
  output armPkg::instrWord instrD,
  input  armPkg::regAddrs  addrsD,
  input  logic [3:0]       waW,
  input  armPkg::ctrlSig   ctrlE,
  input  armPkg::ctrlSig   ctrlM,
  input  armPkg::ctrlSig   ctrlW,
  input  armPkg::fwdSel    forwardA,
  input  armPkg::fwdSel    forwardB,
  input  logic             stallF,
  input  logic             stallD,
  input  logic             bubbleE,
  output armPkg::memReq    dataReq,
  input  logic [31:0]      readDataM
);

  logic [31:0]      pcPlus8D;
  logic [31:0]      rd1D;
  logic [31:0]      rd2D;
  logic [31:0]      immD;
  logic             isMemD;
  logic [31:0]      rd1E;
  logic [31:0]      rd2E;
  logic [31:0]      immE;
  logic [4:0]       shAmtE;
  armPkg::shiftType shKindE;
  logic [31:0]      srcAE;
  logic [31:0]      writeDataE;
  logic [31:0]      shiftedE;
  logic [31:0]      srcBE;
  logic [31:0]      aluResultE;
  logic [31:0]      aluOutM;
  logic [31:0]      writeDataM;
  logic [31:0]      wdataM;
  logic [3:0]       byteEnM;
  logic [31:0]      aluOutW;
  logic [31:0]      readDataW;
  logic [31:0]      loadDataW;
  logic [31:0]      resultW;

  function automatic logic [31:0] pickOperand(input armPkg::fwdSel sel,
                                              input logic [31:0] regVal,
                                              input logic [31:0] memVal,
                                              input logic [31:0] wbVal);
    case (sel)
      armPkg::fromM: return memVal;
      armPkg::fromW: return wbVal;
      default:       return regVal;
    endcase
  endfunction

  // ==========================================================================
  // Fetch
  // ==========================================================================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcF <= resetPc;
    end else if (!stallF) begin
      pcF <= pcF + 32'd4;
    end
  end

  // ==========================================================================
  // Decode
  // ==========================================================================
  // PC plus 8 travels with its instruction for r15 reads
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      instrD   <= '0;
      pcPlus8D <= '0;
    end else if (!stallD) begin
      instrD   <= instrF;
      pcPlus8D <= pcF + 32'd8;
    end
  end

  assign isMemD = (instrD.memView.opClass == 2'b01);

  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .we      (ctrlW.regWrite),
    .ra1     (addrsD.ra1),
    .ra2     (addrsD.ra2),
    .wa      (waW),
    .wd      (resultW),
    .pcPlus8 (pcPlus8D),
    .rd1     (rd1D),
    .rd2     (rd2D)
  );

  immRotator immRotator_i (
    .instr (instrD),
    .isMem (isMemD),
    .imm   (immD)
  );

  // ==========================================================================
  // Execute
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (bubbleE) begin
      rd1E    <= '0;
      rd2E    <= '0;
      immE    <= '0;
      shAmtE  <= '0;
      shKindE <= armPkg::shLsl;
    end else begin
      rd1E    <= rd1D;
      rd2E    <= rd2D;
      immE    <= immD;
      shAmtE  <= instrD.dataProcView.operand[11:7];
      shKindE <= armPkg::shiftType'(instrD.dataProcView.operand[6:5]);
    end
  end

  // Bypass first, then immediate or shifted rm
  assign srcAE      = pickOperand(forwardA, rd1E, aluOutM, resultW);
  assign writeDataE = pickOperand(forwardB, rd2E, aluOutM, resultW);

  barrelShifter barrelShifter_i (
    .value  (writeDataE),
    .kind   (shKindE),
    .amount (shAmtE),
    .result (shiftedE)
  );

  assign srcBE = ctrlE.aluSrcImm ? immE : (ctrlE.useShift ? shiftedE : writeDataE);

  armAlu armAlu_i (
    .a             (srcAE),
    .b             (srcBE),
    .op            (ctrlE.op),
    .invertB       (ctrlE.invertB),
    .reverseInputs (ctrlE.reverseInputs),
    .carryIn       (ctrlE.carryIn),
    .passB         (ctrlE.passB),
    .y             (aluResultE)
  );

  // ==========================================================================
  // Memory
  // ==========================================================================
  always_ff @(posedge clk) begin
    aluOutM    <= aluResultE;
    writeDataM <= writeDataE;
  end

  byteLaneUnit byteLaneUnit_i (
    .storeData   (writeDataM),
    .byteAccess  (ctrlM.byteAccess),
    .addrLow     (aluOutM[1:0]),
    .wdata       (wdataM),
    .byteEn      (byteEnM),
    .loadWordW   (readDataW),
    .byteAccessW (ctrlW.byteAccess),
    .addrLowW    (aluOutW[1:0]),
    .loadData    (loadDataW)
  );

  // ALU result doubles as the address
  assign dataReq.addr   = aluOutM;
  assign dataReq.wdata  = wdataM;
  assign dataReq.byteEn = byteEnM;
  assign dataReq.read   = ctrlM.memRead;
  assign dataReq.write  = ctrlM.memWrite;

  // Store enables agree with the access size
  assert property (@(posedge clk) disable iff (!arstN)
    dataReq.write |-> ($onehot(dataReq.byteEn) || dataReq.byteEn == 4'hF));

  // ==========================================================================
  // Writeback
  // ==========================================================================
  always_ff @(posedge clk) begin
    aluOutW   <= aluOutM;
    readDataW <= readDataM;
  end

  assign resultW = ctrlW.memRead ? loadDataW : aluOutW;

endmodule

// ==== design/armCore.sv ====
module armCore #(
  parameter logic [31:0] resetPc = 32'h0
) (
  input  logic          clk,
  input  logic          arstN,
  output logic [31:0]   pcF,
  input  logic [31:0]   instrF,
  output armPkg::memReq dataReq,
  input  logic [31:0]   readDataM
);

  // Decode word and stage addresses
  armPkg::instrWord instrD;
  armPkg::regAddrs  addrsD;
  armPkg::regAddrs  addrsE;
  logic [3:0]       waM;
  logic [3:0]       waW;

  // Control per stage
  armPkg::ctrlSig ctrlE;
  armPkg::ctrlSig ctrlM;
  armPkg::ctrlSig ctrlW;

  // Hazard results
  armPkg::fwdSel forwardA;
  armPkg::fwdSel forwardB;
  logic          stallF;
  logic          stallD;
  logic          bubbleE;

  // Port names match the wires above
  armDecoder armDecoder_i (.*);

  hazardUnit hazardUnit_i (.*);

  armDatapath #(
    .resetPc (resetPc)
  ) armDatapath_i (.*);

endmodule

// ==== testbench/armCoreTb.sv ====
module armCoreTb;
  timeunit 1ns;
  timeprecision 1ns;

  localparam logic [31:0] progBase = 32'h0;
  localparam int numPrograms = 8;
  localparam int randSlots = 40;
  localparam int clkPeriod = 100;
  localparam int maxProgCycles = 150;
  localparam int watchdogNs = numPrograms * 60 * clkPeriod * 4;
  // MOV r0,r0
  localparam logic [31:0] movR0R0 = 32'hE1A00000;

  logic          clk;
  logic          arstN;
  logic [31:0]   pcF;
  logic [31:0]   instrF;
  armPkg::memReq dataReq;
  logic [31:0]   readDataM;

  // Instruction memory and data memory with its reset image
  logic [31:0] imem [128];
  logic [31:0] dmem [64];
  logic [31:0] dmemInit [64];

  // Reference model state
  logic [31:0]   modelRegs [15];
  logic [31:0]   modelMem [64];
  armPkg::memReq expStores [$];
  logic [31:0]   expLoads [$];
  logic [31:0]   lfsr;
  logic [3:0]    lastDest;
  int            slot;

  int storesChecked;
  int loadsChecked;
  int mismatchCount;
  int unexpectedCount;
  int missingCount;

  armCore #(
    .resetPc (progBase)
  ) dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .pcF       (pcF),
    .instrF    (instrF),
    .dataReq   (dataReq),
    .readDataM (readDataM)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  // ==========================================================================
  // Memories
  // ==========================================================================
  // Same-cycle answers with the word index wrapping inside each array
  assign instrF    = imem[pcF[8:2]];
  assign readDataM = dataReq.read ? dmem[dataReq.addr[7:2]] : 32'h0;

  always @(posedge clk) begin
    if (!arstN) begin
      for (int i = 0; i < 64; i++) begin
        dmem[i] <= dmemInit[i];
      end
    end else if (dataReq.write) begin
      for (int i = 0; i < 4; i++) begin
        if (dataReq.byteEn[i]) begin
          dmem[dataReq.addr[7:2]][8*i +: 8] <= dataReq.wdata[8*i +: 8];
        end
      end
    end
  end

  // ==========================================================================
  // Random source and reference model
  // ==========================================================================
  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] nextBits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hD0000001) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] rotateRight(input logic [31:0] v, input logic [4:0] amt);
    if (amt == 5'd0) begin
      return v;
    end
    return (v >> amt) | (v << (6'd32 - amt));
  endfunction

  // Immediate shifts where an encoded 0 means 32 for LSR and ASR
  function automatic logic [31:0] shiftOperand(input logic [31:0] v, input logic [1:0] kind,
                                               input logic [4:0] amt);
    case (kind)
      2'd0: return v << amt;
      2'd1: return (amt == 5'd0) ? 32'd0 : (v >> amt);
      2'd2: begin
        if (amt == 5'd0) begin
          return {32{v[31]}};
        end
        return $signed(v) >>> amt;
      end
      default: return rotateRight(v, amt);
    endcase
  endfunction

  function automatic logic [31:0] aluResult(input logic [3:0] op, input logic [31:0] a,
                                            input logic [31:0] b);
    case (op)
      4'b0000: return a & b;
      4'b0001: return a ^ b;
      4'b0010: return a - b;
      4'b0011: return b - a;
      4'b0100: return a + b;
      4'b1100: return a | b;
      4'b1101: return b;
      4'b1110: return a & ~b;
      default: return ~b;
    endcase
  endfunction

  // PC reads as instruction address plus 8
  function automatic logic [31:0] readReg(input logic [3:0] idx, input logic [31:0] pc);
    if (idx == 4'd15) begin
      return pc + 32'd8;
    end
    return modelRegs[idx];
  endfunction

  // Executes one instruction word in program order
  task automatic execute(input logic [31:0] pc, input logic [31:0] word);
    logic [31:0]   a;
    logic [31:0]   b;
    logic [31:0]   addr;
    logic [31:0]   data;
    armPkg::memReq st;
    a = readReg(word[19:16], pc);
    if (word[27:26] == 2'b00) begin
      if (word[25]) begin
        b = rotateRight({24'b0, word[7:0]}, {word[11:8], 1'b0});
      end else begin
        b = shiftOperand(readReg(word[3:0], pc), word[6:5], word[11:7]);
      end
      modelRegs[word[15:12]] = aluResult(word[24:21], a, b);
    end else begin
      addr = word[23] ? a + {20'b0, word[11:0]} : a - {20'b0, word[11:0]};
      if (word[20]) begin
        data = modelMem[addr[7:2]];
        if (word[22]) begin
          data = {24'b0, data[8*addr[1:0] +: 8]};
        end
        modelRegs[word[15:12]] = data;
        expLoads.push_back(addr);
      end else begin
        data     = readReg(word[15:12], pc);
        st.addr  = addr;
        st.read  = 1'b0;
        st.write = 1'b1;
        if (word[22]) begin
          // Byte store puts the low byte on all lanes
          st.wdata  = {4{data[7:0]}};
          st.byteEn = 4'b0001 << addr[1:0];
        end else begin
          st.wdata  = data;
          st.byteEn = 4'hF;
        end
        for (int i = 0; i < 4; i++) begin
          if (st.byteEn[i]) begin
            modelMem[addr[7:2]][8*i +: 8] = st.wdata[8*i +: 8];
          end
        end
        expStores.push_back(st);
      end
    end
  endtask

  // ==========================================================================
  // Program generator
  // ==========================================================================
  task automatic emit(input logic [31:0] word);
    imem[slot] = word;
    execute(progBase + 32'(slot * 4), word);
    slot++;
  endtask

  function automatic logic [3:0] pickOpcode();
    logic [31:0] r;
    r = nextBits(4) % 9;
    case (r)
      0: return 4'b0000;
      1: return 4'b0001;
      2: return 4'b0010;
      3: return 4'b0011;
      4: return 4'b0100;
      5: return 4'b1100;
      6: return 4'b1101;
      7: return 4'b1110;
      default: return 4'b1111;
    endcase
  endfunction

  // Biased toward the last result with r15 now and then
  function automatic logic [3:0] pickSource();
    logic [3:0] r;
    r = 4'(nextBits(4));
    if (r == 4'd15) begin
      return 4'd15;
    end else if (r[3]) begin
      return lastDest;
    end
    return {1'b0, r[2:0]};
  endfunction

  task automatic emitDataProc();
    logic [3:0] op;
    logic [3:0] rn;
    logic [3:0] rm;
    logic [3:0] rd;
    logic [4:0] amt;
    logic [1:0] kind;
    logic [3:0] rot;
    logic [7:0] imm8;
    op = pickOpcode();
    rn = 4'd0;
    // MOV and MVN leave rn at zero
    if (op != 4'b1101 && op != 4'b1111) begin
      rn = pickSource();
    end
    rd = {1'b0, 3'(nextBits(3))};
    if (nextBits(1) == 32'd1) begin
      rot  = 4'(nextBits(4));
      imm8 = 8'(nextBits(8));
      emit({4'hE, 3'b001, op, 1'b0, rn, rd, rot, imm8});
    end else begin
      rm   = pickSource();
      kind = 2'(nextBits(2));
      amt  = 5'd0;
      // Zero amount a quarter of the time
      if (nextBits(2) != 32'd0) begin
        amt = 5'(nextBits(5));
      end
      emit({4'hE, 3'b000, op, 1'b0, rn, rd, amt, kind, 1'b0, rm});
    end
    lastDest = rd;
  endtask

  // MOV of the base followed at once by the transfer that uses it
  task automatic emitTransfer(input logic load);
    logic [2:0] rb;
    logic [3:0] rd;
    logic       up;
    logic       isByte;
    int         base;
    int         limit;
    int         off;
    rb     = 3'(nextBits(3));
    base   = 4 * int'(nextBits(6));
    isByte = 1'(nextBits(1));
    up     = 1'(nextBits(1));
    // Final address stays inside the 256-byte window
    limit  = up ? 255 - base : base;
    off    = int'(nextBits(8)) % (limit + 1);
    if (!isByte) begin
      off = off & ~3;
    end
    if (load || nextBits(1) == 32'd0) begin
      rd = {1'b0, 3'(nextBits(3))};
    end else begin
      rd = lastDest;
    end
    emit({4'hE, 3'b001, 4'b1101, 1'b0, 4'h0, 1'b0, rb, 4'h0, base[7:0]});
    emit({4'hE, 3'b010, 1'b1, up, isByte, 1'b0, load, 1'b0, rb, rd, 4'h0, off[7:0]});
    if (load) begin
      lastDest = rd;
    end
  endtask

  task automatic genProgram();
    logic [2:0] kind;
    int         off;
    for (int i = 0; i < 128; i++) begin
      imem[i] = movR0R0;
    end
    for (int i = 0; i < 64; i++) begin
      dmemInit[i] = nextBits(32);
      modelMem[i] = dmemInit[i];
    end
    for (int i = 0; i < 15; i++) begin
      modelRegs[i] = '0;
    end
    expStores.delete();
    expLoads.delete();
    lastDest = 4'd0;
    slot     = 0;
    while (slot < randSlots) begin
      kind = 3'(nextBits(3));
      if (kind >= 3'd6 && slot < randSlots - 1) begin
        emitTransfer(kind == 3'd6);
      end else begin
        emitDataProc();
      end
    end
    // Register dump through PC-relative stores
    for (int r = 0; r < 8; r++) begin
      off = 4 * int'(nextBits(6));
      emit({4'hE, 3'b010, 5'b11000, 4'hF, 4'(r), 4'h0, off[7:0]});
    end
    for (int i = 0; i < 6; i++) begin
      emit(movR0R0);
    end
  endtask

  // ==========================================================================
  // Store and load checkers
  // ==========================================================================
  // Sampled mid-cycle when dataReq has settled
  always @(negedge clk) begin
    armPkg::memReq want;
    if (arstN && dataReq.write) begin
      assert (expStores.size() > 0) else begin
        $display("Store to address %h arrived with no store left in the model",
                 dataReq.addr);
        unexpectedCount++;
      end
      if (expStores.size() > 0) begin
        want = expStores.pop_front();
        storesChecked++;
        assert (dataReq.addr == want.addr) else begin
          $display("[ERROR] dataReq.addr got %h expected %h", dataReq.addr, want.addr);
          mismatchCount++;
        end
        assert (dataReq.wdata == want.wdata) else begin
          $display("[ERROR] dataReq.wdata got %h expected %h", dataReq.wdata, want.wdata);
          mismatchCount++;
        end
        assert (dataReq.byteEn == want.byteEn) else begin
          $display("[ERROR] dataReq.byteEn got %h expected %h", dataReq.byteEn,
                   want.byteEn);
          mismatchCount++;
        end
      end
    end
  end

  // Each load shows up once on dataReq.read at its model address
  always @(negedge clk) begin
    logic [31:0] wantAddr;
    if (arstN && dataReq.read) begin
      assert (expLoads.size() > 0) else begin
        $display("Load from address %h arrived with no load left in the model",
                 dataReq.addr);
        unexpectedCount++;
      end
      if (expLoads.size() > 0) begin
        wantAddr = expLoads.pop_front();
        loadsChecked++;
        assert (dataReq.addr == wantAddr) else begin
          $display("[ERROR] dataReq.addr got %h expected %h", dataReq.addr, wantAddr);
          mismatchCount++;
        end
      end
    end
  end

  // ==========================================================================
  // Sequence and watchdog
  // ==========================================================================
  initial begin
    int cycles;
    int totalErrors;
    storesChecked   = 0;
    loadsChecked    = 0;
    mismatchCount   = 0;
    unexpectedCount = 0;
    missingCount    = 0;
    lfsr            = 32'h616a26aa;
    arstN           = 1'b0;
    for (int p = 0; p < numPrograms; p++) begin
      genProgram();
      repeat (4) @(posedge clk);
      @(negedge clk);
      arstN  = 1'b1;
      cycles = 0;
      while ((expStores.size() > 0 || expLoads.size() > 0) && cycles < maxProgCycles) begin
        @(posedge clk);
        cycles++;
      end
      assert (expStores.size() == 0) else begin
        $display("Program %0d ended with %0d expected stores never seen on dataReq",
                 p, expStores.size());
        missingCount += expStores.size();
      end
      assert (expLoads.size() == 0) else begin
        $display("Program %0d ended with %0d expected loads never seen on dataReq",
                 p, expLoads.size());
        missingCount += expLoads.size();
      end
      expStores.delete();
      expLoads.delete();
      // Only fillers remain so any store or load here is unexpected
      repeat (4) @(negedge clk);
      arstN = 1'b0;
    end
    totalErrors = mismatchCount + unexpectedCount + missingCount;
    $display("Stores checked %0d, loads checked %0d, mismatches %0d, unexpected %0d, missing %0d",
             storesChecked, loadsChecked, mismatchCount, unexpectedCount, missingCount);
    if (totalErrors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  initial begin
    #(watchdogNs);
    $display("Watchdog expired after %0d ns before all programs finished", watchdogNs);
    $display("Done: errors found");
    $finish;
  end

endmodule

// ==== armLite.f ====
design/armPkg.sv
design/immRotator.sv
design/barrelShifter.sv
design/armAlu.sv
design/regFile.sv
design/byteLaneUnit.sv
design/armDecoder.sv
design/hazardUnit.sv
design/armDatapath.sv
design/armCore.sv
testbench/armCoreTb.sv

// ==== Makefile ====
# Verilator flow for the armLite core and its testbench

VERILATOR ?= verilator
TOP       ?= armCoreTb
FILELIST  ?= armLite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := Done: no errors
FAIL_MSG  := Done: errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
